/* rtl/manycore_pkg.sv */
/*
  packet field widths and encodings for the remote-memory endpoint
  opcodes and response types are 2 bits wide, matching the mesh packet format
  ret_type value 2'b11 is unused and never leaves the endpoint
*/

package manycore_pkg;

  // payload and routing fields
  localparam int data_width_c    = 32;
  localparam int x_cord_width_c  = 4;
  localparam int y_cord_width_c  = 4;
  localparam int reg_id_width_c  = 5;   // requester tag

  // request opcodes
  typedef enum logic [1:0] {
    op_store   = 2'b00,
    op_load    = 2'b01,
    op_amoadd  = 2'b10,   // returns old value
    op_amoswap = 2'b11    // returns old value
  } packet_op_e;

  // response types sent back to the requester
  typedef enum logic [1:0] {
    ret_credit = 2'b00,   // store acknowledge, no data
    ret_int    = 2'b01,   // carries a data word
    ret_err    = 2'b10    // misrouted or out of range
  } return_type_e;

endpackage

/* rtl/manycore_cfg_pkg.sv */
/*
  fixed tile geometry for this endpoint
  data memory depth must be a power of two
  request address is wider than the memory so bad addresses can be flagged
*/

package manycore_cfg_pkg;

  localparam int tile_x_c = 3;
  localparam int tile_y_c = 2;

  // data memory, in 32-bit words
  localparam int dmem_words_c      = 256;
  localparam int dmem_addr_width_c = $clog2(dmem_words_c);

  // word address as carried in the packet
  localparam int req_addr_width_c  = 12;

endpackage

/* rtl/packet_decode.sv */
/*
  first stage registers each request strobe and flags bad packets
  a packet is an error if it is not for this tile or its word address
  is past the end of data memory; only the low address bits go forward
  no back-pressure so a request may arrive every cycle
*/

`timescale 1ns/1ps

module packet_decode
  import manycore_pkg::*;
  import manycore_cfg_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,

  input  logic                         req_v_i,
  input  packet_op_e                   req_op_i,
  input  logic [req_addr_width_c-1:0]  req_addr_i,
  input  logic [data_width_c-1:0]      req_data_i,
  input  logic [reg_id_width_c-1:0]    req_reg_id_i,
  input  logic [x_cord_width_c-1:0]    req_src_x_i,
  input  logic [y_cord_width_c-1:0]    req_src_y_i,
  input  logic [x_cord_width_c-1:0]    req_dst_x_i,
  input  logic [y_cord_width_c-1:0]    req_dst_y_i,

  output logic                         d_v_o,
  output packet_op_e                   d_op_o,
  output logic                         d_err_o,
  output logic [dmem_addr_width_c-1:0] d_addr_o,
  output logic [data_width_c-1:0]      d_data_o,
  output logic [reg_id_width_c-1:0]    d_reg_id_o,
  output logic [x_cord_width_c-1:0]    d_src_x_o,
  output logic [y_cord_width_c-1:0]    d_src_y_o
);

  logic misrouted;
  logic out_of_range;
  logic req_err;

  assign misrouted    = (req_dst_x_i != x_cord_width_c'(tile_x_c))
                     || (req_dst_y_i != y_cord_width_c'(tile_y_c));
  assign out_of_range = (req_addr_i >= req_addr_width_c'(dmem_words_c));
  assign req_err      = misrouted || out_of_range;

  // valid bit
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      d_v_o <= 1'b0;
    end else begin
      d_v_o <= req_v_i;
    end
  end

  // payload captured every cycle
  always_ff @(posedge clk_i) begin
    d_op_o     <= req_op_i;
    d_err_o    <= req_err;
    d_addr_o   <= req_addr_i[dmem_addr_width_c-1:0];  // upper bits checked above
    d_data_o   <= req_data_i;
    d_reg_id_o <= req_reg_id_i;
    d_src_x_o  <= req_src_x_i;
    d_src_y_o  <= req_src_y_i;
  end

  // the loader must never send a strobe with an undriven opcode
  req_op_known_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    req_v_i |-> !$isunknown(req_op_i)
  ) else $error("packet_decode: valid request with unknown opcode");

endmodule

/* rtl/dmem_execute.sv */
/*
  second stage holds the data memory and performs the operation
  memory is read combinationally and written at the same edge that
  loads the stage register, so back-to-back ops to one word see the
  previous result without forwarding
  memory contents are not cleared by reset
*/

`timescale 1ns/1ps

module dmem_execute
  import manycore_pkg::*;
  import manycore_cfg_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,

  input  logic                         d_v_i,
  input  packet_op_e                   d_op_i,
  input  logic                         d_err_i,
  input  logic [dmem_addr_width_c-1:0] d_addr_i,
  input  logic [data_width_c-1:0]      d_data_i,
  input  logic [reg_id_width_c-1:0]    d_reg_id_i,
  input  logic [x_cord_width_c-1:0]    d_src_x_i,
  input  logic [y_cord_width_c-1:0]    d_src_y_i,

  output logic                         x_v_o,
  output packet_op_e                   x_op_o,
  output logic                         x_err_o,
  output logic [data_width_c-1:0]      x_rdata_o,
  output logic [reg_id_width_c-1:0]    x_reg_id_o,
  output logic [x_cord_width_c-1:0]    x_src_x_o,
  output logic [y_cord_width_c-1:0]    x_src_y_o
);

  logic [data_width_c-1:0] mem [dmem_words_c];

  logic [data_width_c-1:0] old_word;
  logic [data_width_c-1:0] new_word;
  logic                    mem_we;

  assign old_word = mem[d_addr_i];

  // loads leave the word alone; error packets never touch memory
  assign mem_we = d_v_i && !d_err_i && (d_op_i != op_load);

  always_comb begin
    case (d_op_i)
      op_amoadd: new_word = old_word + d_data_i;  // wraps at 32 bits
      default:   new_word = d_data_i;             // store and swap
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (mem_we) begin
      mem[d_addr_i] <= new_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      x_v_o <= 1'b0;
    end else begin
      x_v_o <= d_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    x_op_o     <= d_op_i;
    x_err_o    <= d_err_i;
    x_rdata_o  <= old_word;   // value before this op for loads and atomics
    x_reg_id_o <= d_reg_id_i;
    x_src_x_o  <= d_src_x_i;
    x_src_y_o  <= d_src_y_i;
  end

  // an error packet leaves its target word as it was
  err_no_write_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (d_v_i && d_err_i) |=> (mem[$past(d_addr_i)] == $past(old_word))
  ) else $error("dmem_execute: memory changed by an error request");

endmodule

/* rtl/response_result.sv */
/*
  third stage: builds the response packet for each executed request
  stores get a credit with zero data, errors get ret_err with zero data,
  loads and atomics return the old memory word
  response goes back to the request's source tile
*/

`timescale 1ns/1ps

module response_result
  import manycore_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,

  input  logic                      x_v_i,
  input  packet_op_e                x_op_i,
  input  logic                      x_err_i,
  input  logic [data_width_c-1:0]   x_rdata_i,
  input  logic [reg_id_width_c-1:0] x_reg_id_i,
  input  logic [x_cord_width_c-1:0] x_src_x_i,
  input  logic [y_cord_width_c-1:0] x_src_y_i,

  output logic                      resp_v_o,
  output return_type_e              resp_type_o,
  output logic [data_width_c-1:0]   resp_data_o,
  output logic [reg_id_width_c-1:0] resp_reg_id_o,
  output logic [x_cord_width_c-1:0] resp_dst_x_o,
  output logic [y_cord_width_c-1:0] resp_dst_y_o
);

  return_type_e            ret_type;
  logic [data_width_c-1:0] ret_data;

  always_comb begin
    if (x_err_i) begin
      ret_type = ret_err;
    end else if (x_op_i == op_store) begin
      ret_type = ret_credit;
    end else begin
      ret_type = ret_int;   // load, amoadd, amoswap
    end
  end

  assign ret_data = (ret_type == ret_int) ? x_rdata_i : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_v_o <= 1'b0;
    end else begin
      resp_v_o <= x_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_type_o   <= ret_type;
    resp_data_o   <= ret_data;
    resp_reg_id_o <= x_reg_id_i;
    resp_dst_x_o  <= x_src_x_i;   // reply to sender
    resp_dst_y_o  <= x_src_y_i;
  end

  // only the three defined response types may leave the tile
  resp_type_known_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    resp_v_o |-> (resp_type_o inside {ret_credit, ret_int, ret_err})
  ) else $error("response_result: response with unknown type");

endmodule

/* rtl/manycore_endpoint.sv */
/*
  remote-memory endpoint of one manycore tile
  three register stages, decode then execute then result, so every
  request gets exactly one response 3 cycles later, in order
  no back-pressure in either direction
*/

`timescale 1ns/1ps

module manycore_endpoint
  import manycore_pkg::*;
  import manycore_cfg_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,

  input  logic                        req_v_i,
  input  packet_op_e                  req_op_i,
  input  logic [req_addr_width_c-1:0] req_addr_i,
  input  logic [data_width_c-1:0]     req_data_i,
  input  logic [reg_id_width_c-1:0]   req_reg_id_i,
  input  logic [x_cord_width_c-1:0]   req_src_x_i,
  input  logic [y_cord_width_c-1:0]   req_src_y_i,
  input  logic [x_cord_width_c-1:0]   req_dst_x_i,
  input  logic [y_cord_width_c-1:0]   req_dst_y_i,

  output logic                        resp_v_o,
  output return_type_e                resp_type_o,
  output logic [data_width_c-1:0]     resp_data_o,
  output logic [reg_id_width_c-1:0]   resp_reg_id_o,
  output logic [x_cord_width_c-1:0]   resp_dst_x_o,
  output logic [y_cord_width_c-1:0]   resp_dst_y_o
);

  // decode -> execute
  logic                         d_v;
  packet_op_e                   d_op;
  logic                         d_err;
  logic [dmem_addr_width_c-1:0] d_addr;
  logic [data_width_c-1:0]      d_data;
  logic [reg_id_width_c-1:0]    d_reg_id;
  logic [x_cord_width_c-1:0]    d_src_x;
  logic [y_cord_width_c-1:0]    d_src_y;

  // execute -> result
  logic                         x_v;
  packet_op_e                   x_op;
  logic                         x_err;
  logic [data_width_c-1:0]      x_rdata;
  logic [reg_id_width_c-1:0]    x_reg_id;
  logic [x_cord_width_c-1:0]    x_src_x;
  logic [y_cord_width_c-1:0]    x_src_y;

  packet_decode decode (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.req_v_i(req_v_i)
    ,.req_op_i(req_op_i)
    ,.req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i)
    ,.req_reg_id_i(req_reg_id_i)
    ,.req_src_x_i(req_src_x_i)
    ,.req_src_y_i(req_src_y_i)
    ,.req_dst_x_i(req_dst_x_i)
    ,.req_dst_y_i(req_dst_y_i)
    ,.d_v_o(d_v)
    ,.d_op_o(d_op)
    ,.d_err_o(d_err)
    ,.d_addr_o(d_addr)
    ,.d_data_o(d_data)
    ,.d_reg_id_o(d_reg_id)
    ,.d_src_x_o(d_src_x)
    ,.d_src_y_o(d_src_y)
  );

  dmem_execute execute (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.d_v_i(d_v)
    ,.d_op_i(d_op)
    ,.d_err_i(d_err)
    ,.d_addr_i(d_addr)
    ,.d_data_i(d_data)
    ,.d_reg_id_i(d_reg_id)
    ,.d_src_x_i(d_src_x)
    ,.d_src_y_i(d_src_y)
    ,.x_v_o(x_v)
    ,.x_op_o(x_op)
    ,.x_err_o(x_err)
    ,.x_rdata_o(x_rdata)
    ,.x_reg_id_o(x_reg_id)
    ,.x_src_x_o(x_src_x)
    ,.x_src_y_o(x_src_y)
  );

  response_result result (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.x_v_i(x_v)
    ,.x_op_i(x_op)
    ,.x_err_i(x_err)
    ,.x_rdata_i(x_rdata)
    ,.x_reg_id_i(x_reg_id)
    ,.x_src_x_i(x_src_x)
    ,.x_src_y_i(x_src_y)
    ,.resp_v_o(resp_v_o)
    ,.resp_type_o(resp_type_o)
    ,.resp_data_o(resp_data_o)
    ,.resp_reg_id_o(resp_reg_id_o)
    ,.resp_dst_x_o(resp_dst_x_o)
    ,.resp_dst_y_o(resp_dst_y_o)
  );

endmodule

/* tb/endpoint_testbench.sv */
/*
  testbench for the manycore remote-memory endpoint
  data memory is not cleared by reset, so every word is stored once
  before any test reads it; the model memory mirrors those stores
  responses are expected exactly 3 cycles after the request is driven
*/

`timescale 1ns/1ps

module endpoint_testbench
  import manycore_pkg::*;
  import manycore_cfg_pkg::*;
;

  localparam int total_reqs_c  = 256 + 64 + 400;  // fill, directed, random
  localparam int watchdog_ns_c = total_reqs_c * 20 + 4000;

  typedef struct packed {
    return_type_e                rtype;
    logic [data_width_c-1:0]     data;
    logic [reg_id_width_c-1:0]   reg_id;
    logic [x_cord_width_c-1:0]   dst_x;
    logic [y_cord_width_c-1:0]   dst_y;
    logic [31:0]                 due;     // cycle the response must show up
  } resp_t;

  logic                        clk_i;
  logic                        rst_i;
  logic                        req_v_i;
  packet_op_e                  req_op_i;
  logic [req_addr_width_c-1:0] req_addr_i;
  logic [data_width_c-1:0]     req_data_i;
  logic [reg_id_width_c-1:0]   req_reg_id_i;
  logic [x_cord_width_c-1:0]   req_src_x_i;
  logic [y_cord_width_c-1:0]   req_src_y_i;
  logic [x_cord_width_c-1:0]   req_dst_x_i;
  logic [y_cord_width_c-1:0]   req_dst_y_i;
  logic                        resp_v_o;
  return_type_e                resp_type_o;
  logic [data_width_c-1:0]     resp_data_o;
  logic [reg_id_width_c-1:0]   resp_reg_id_o;
  logic [x_cord_width_c-1:0]   resp_dst_x_o;
  logic [y_cord_width_c-1:0]   resp_dst_y_o;

  logic [data_width_c-1:0] model_mem [dmem_words_c];
  resp_t                   exp_q [$];
  logic [31:0]             cyc = 32'd0;
  logic [31:0]             lcg_state = 32'h8aa6_e5ef;
  int                      errors = 0;
  int                      checks = 0;
  int                      tests = 0;
  int                      test_start_errors = 0;

  manycore_endpoint dut (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.req_v_i(req_v_i)
    ,.req_op_i(req_op_i)
    ,.req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i)
    ,.req_reg_id_i(req_reg_id_i)
    ,.req_src_x_i(req_src_x_i)
    ,.req_src_y_i(req_src_y_i)
    ,.req_dst_x_i(req_dst_x_i)
    ,.req_dst_y_i(req_dst_y_i)
    ,.resp_v_o(resp_v_o)
    ,.resp_type_o(resp_type_o)
    ,.resp_data_o(resp_data_o)
    ,.resp_reg_id_o(resp_reg_id_o)
    ,.resp_dst_x_o(resp_dst_x_o)
    ,.resp_dst_y_o(resp_dst_y_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 32'd1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] fill_word(logic [31:0] a);
    return (a * 32'h9e37_79b9) ^ 32'h3c3c_0000 ^ a;
  endfunction

  // expected type and data from the endpoint rules; updates the model memory
  function automatic resp_t model_apply(packet_op_e op, logic [req_addr_width_c-1:0] addr,
                                        logic [data_width_c-1:0] data,
                                        logic [x_cord_width_c-1:0] dst_x,
                                        logic [y_cord_width_c-1:0] dst_y);
    resp_t                        r;
    logic [data_width_c-1:0]      old;
    logic [dmem_addr_width_c-1:0] w;
    r = '0;
    w = addr[dmem_addr_width_c-1:0];
    if (dst_x != 4'(tile_x_c) || dst_y != 4'(tile_y_c)
        || addr >= 12'(dmem_words_c)) begin
      r.rtype = ret_err;
    end else begin
      old = model_mem[w];
      case (op)
        op_store: begin
          model_mem[w] = data;
          r.rtype = ret_credit;
        end
        op_load: begin
          r.rtype = ret_int;
          r.data = old;
        end
        op_amoadd: begin
          model_mem[w] = old + data;   // 32-bit wrap
          r.rtype = ret_int;
          r.data = old;
        end
        default: begin
          model_mem[w] = data;
          r.rtype = ret_int;
          r.data = old;
        end
      endcase
    end
    return r;
  endfunction

  // called at posedge + 2 ns and returns at the next posedge + 2 ns
  task automatic send_req(input packet_op_e op, input logic [11:0] addr,
                          input logic [31:0] data, input logic [4:0] reg_id,
                          input logic [3:0] src_x, input logic [3:0] src_y,
                          input logic [3:0] dst_x, input logic [3:0] dst_y);
    resp_t e;
    req_v_i      = 1'b1;
    req_op_i     = op;
    req_addr_i   = addr;
    req_data_i   = data;
    req_reg_id_i = reg_id;
    req_src_x_i  = src_x;
    req_src_y_i  = src_y;
    req_dst_x_i  = dst_x;
    req_dst_y_i  = dst_y;
    e = model_apply(op, addr, data, dst_x, dst_y);
    e.reg_id = reg_id;
    e.dst_x  = src_x;
    e.dst_y  = src_y;
    e.due    = cyc + 32'd3;
    exp_q.push_back(e);
    @(posedge clk_i);
    #2;
  endtask

  task automatic send_local(input packet_op_e op, input logic [11:0] addr,
                            input logic [31:0] data, input logic [4:0] reg_id);
    send_req(op, addr, data, reg_id, reg_id[3:0], ~reg_id[3:0],
             4'(tile_x_c), 4'(tile_y_c));
  endtask

  task automatic check_idle();
    checks++;
    assert (resp_v_o === 1'b0) else begin
      $display("FAILED %0t: resp_v_o high with no request sent", $time);
      errors++;
    end
  endtask

  // idle the inputs until the outstanding responses are in and then report
  task automatic end_test(input string name);
    req_v_i = 1'b0;
    for (int i = 0; i < 8 && exp_q.size() != 0; i++) begin
      @(posedge clk_i);
      #2;
    end
    tests++;
    if (errors == test_start_errors) $display("test %-10s ok", name);
    else $display("test %-10s %0d error(s)", name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  // responses sampled mid-cycle where outputs are settled
  always @(negedge clk_i) begin
    resp_t e;
    if (!rst_i) begin
      if (resp_v_o) begin
        checks++;
        assert (exp_q.size() != 0) else begin
          $display("unexpected response at %0t with no request outstanding", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          assert (e.due == cyc) else begin
            $display("FAILED %0t: response in cycle %0d, expected %0d", $time, cyc, e.due);
            errors++;
          end
          assert (resp_type_o == e.rtype) else begin
            $display("FAILED %0t: type %s, expected %s", $time,
                     resp_type_o.name(), e.rtype.name());
            errors++;
          end
          assert (resp_data_o == e.data) else begin
            $display("FAILED %0t: data %h, expected %h", $time, resp_data_o, e.data);
            errors++;
          end
          assert (resp_reg_id_o == e.reg_id) else begin
            $display("FAILED %0t: reg_id %0d, expected %0d", $time, resp_reg_id_o, e.reg_id);
            errors++;
          end
          assert (resp_dst_x_o == e.dst_x && resp_dst_y_o == e.dst_y) else begin
            $display("FAILED %0t: dst (%0d,%0d), expected (%0d,%0d)", $time,
                     resp_dst_x_o, resp_dst_y_o, e.dst_x, e.dst_y);
            errors++;
          end
        end
      end else begin
        assert (exp_q.size() == 0 || exp_q[0].due > cyc) else begin
          $display("missing response for reg_id %0d at %0t", exp_q[0].reg_id, $time);
          errors++;
          void'(exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    #(watchdog_ns_c);
    $display("watchdog: simulation did not complete in %0d ns", watchdog_ns_c);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] wdata;
    logic [11:0] addr;
    logic [3:0]  dst_x;
    logic [3:0]  dst_y;
    rst_i        = 1'b1;
    req_v_i      = 1'b0;
    req_op_i     = op_load;
    req_addr_i   = '0;
    req_data_i   = '0;
    req_reg_id_i = '0;
    req_src_x_i  = '0;
    req_src_y_i  = '0;
    req_dst_x_i  = '0;
    req_dst_y_i  = '0;

    // reset held for 4 cycles while outputs stay quiet
    @(posedge clk_i);
    repeat (3) begin
      @(negedge clk_i);
      check_idle();
      @(posedge clk_i);
    end
    #2;
    rst_i = 1'b0;
    repeat (6) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    #2;
    end_test("reset");

    for (int a = 0; a < dmem_words_c; a++) begin
      send_local(op_store, 12'(a), fill_word(32'(a)), 5'(a));
    end
    end_test("fill");

    send_local(op_store, 12'd5, 32'hdead_beef, 5'd1);
    send_local(op_store, 12'd6, 32'h0123_4567, 5'd2);
    send_local(op_store, 12'd200, 32'hcafe_f00d, 5'd3);
    send_local(op_load, 12'd5, 32'h0, 5'd4);
    send_local(op_load, 12'd200, 32'h0, 5'd5);
    send_local(op_load, 12'd6, 32'h0, 5'd31);
    end_test("store_load");

    send_local(op_store, 12'd10, 32'hffff_fff8, 5'd6);
    send_local(op_amoadd, 12'd10, 32'd16, 5'd7);   // wraps past zero
    send_local(op_load, 12'd10, 32'h0, 5'd8);
    for (int i = 0; i < 4; i++) begin
      send_local(op_amoadd, 12'd11, 32'h1111_0001 + 32'(i), 5'(9 + i));
    end
    send_local(op_load, 12'd11, 32'h0, 5'd13);
    end_test("amoadd");

    send_local(op_amoswap, 12'd20, 32'haaaa_5555, 5'd14);
    send_local(op_amoswap, 12'd20, 32'h5555_aaaa, 5'd15);
    send_local(op_load, 12'd20, 32'h0, 5'd16);
    end_test("amoswap");

    send_req(op_store, 12'd30, 32'h1234_5678, 5'd17, 4'd1, 4'd1,
             4'(tile_x_c + 1), 4'(tile_y_c));
    send_req(op_amoswap, 12'd30, 32'h8765_4321, 5'd18, 4'd1, 4'd1,
             4'(tile_x_c), 4'(tile_y_c + 1));
    send_local(op_store, 12'd256, 32'hbad0_0001, 5'd19);    // aliases word 0
    send_local(op_load, 12'd4095, 32'h0, 5'd20);
    send_local(op_amoadd, 12'd300, 32'h0000_0100, 5'd21);   // aliases word 44
    send_local(op_load, 12'd30, 32'h0, 5'd22);
    send_local(op_load, 12'd44, 32'h0, 5'd23);
    send_local(op_load, 12'd0, 32'h0, 5'd24);
    end_test("errors");

    // back-to-back random traffic with about 1 in 16 misrouted or out of range
    for (int i = 0; i < 400; i++) begin
      r = lcg_next();
      wdata = lcg_next();
      addr = {4'h0, r[7:0]};
      dst_x = 4'(tile_x_c);
      dst_y = 4'(tile_y_c);
      if (r[27:24] == 4'h0) begin
        if (r[23]) addr = 12'h100 | r[11:0];
        else if (r[22]) dst_x = dst_x ^ 4'h1;
        else dst_y = dst_y ^ 4'h4;
      end
      send_req(packet_op_e'(r[31:30]), addr, wdata, r[16:12],
               r[21:18], wdata[11:8], dst_x, dst_y);
    end
    end_test("random");

    checks++;
    assert (exp_q.size() == 0) else begin
      $display("%0d responses missing at end of run", exp_q.size());
      errors++;
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* verilog.f */
rtl/manycore_pkg.sv
rtl/manycore_cfg_pkg.sv
rtl/packet_decode.sv
rtl/dmem_execute.sv
rtl/response_result.sv
rtl/manycore_endpoint.sv
tb/endpoint_testbench.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the endpoint testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module endpoint_testbench \
  -f verilog.f \
  -o sim_endpoint

sim_out=$(./obj_dir/sim_endpoint)
echo "$sim_out"

if grep -qxF "Finished with no errors" <<< "$sim_out"; then
  exit 0
fi
exit 1
